// ==== include/ex_defines.svh ====
`ifndef EX_DEFINES_SVH
`define EX_DEFINES_SVH

// ---------------------------------------------------------
// Execute stage widths
// ---------------------------------------------------------

// Data path and PC width
`define EX_XLEN 32

// Scoreboard transaction ID
`define EX_TRANS_ID_BITS 3

// CSR address, taken from the low bits of operand B
`define EX_CSR_ADDR_BITS 12

// Operator encoding width
`define EX_OP_BITS 5

// Instruction sizes for the link address
`define EX_INSTR_BYTES 4
`define EX_CINSTR_BYTES 2

`endif

// ==== source/ex_pkg.sv ====
`include "ex_defines.svh"

package ex_pkg;

    // ---------------------------------------------------------
    // Operators of the fixed latency units
    // ---------------------------------------------------------
    typedef enum logic [`EX_OP_BITS-1:0] {
        // ALU
        OP_ADD   = 5'd0,
        OP_SUB   = 5'd1,
        OP_AND   = 5'd2,
        OP_OR    = 5'd3,
        OP_XOR   = 5'd4,
        OP_SLL   = 5'd5,
        OP_SRL   = 5'd6,
        OP_SRA   = 5'd7,
        OP_SLT   = 5'd8,
        OP_SLTU  = 5'd9,
        // Branch unit, comparison done in the ALU
        OP_BEQ   = 5'd10,
        OP_BNE   = 5'd11,
        OP_BLT   = 5'd12,
        OP_BGE   = 5'd13,
        OP_BLTU  = 5'd14,
        OP_BGEU  = 5'd15,
        OP_JALR  = 5'd16,
        // Multiplier
        OP_MUL   = 5'd17,
        OP_MULHU = 5'd18,
        // CSR buffer
        OP_CSR   = 5'd19
    } fu_op_e;

endpackage

// ==== source/ex_alu.sv ====
`timescale 1ns/1ps
`include "ex_defines.svh"

module ex_alu (
    input  ex_pkg::fu_op_e        operator_i,
    input  logic [`EX_XLEN-1:0]   operand_a_i,
    input  logic [`EX_XLEN-1:0]   operand_b_i,
    output logic [`EX_XLEN-1:0]   result_o,
    output logic                  branch_res_o
);

    logic [4:0] shamt;
    logic       less_signed;
    logic       less_unsigned;
    logic       equal;

    assign shamt         = operand_b_i[4:0];
    assign less_signed   = $signed(operand_a_i) < $signed(operand_b_i);
    assign less_unsigned = operand_a_i < operand_b_i;
    assign equal         = operand_a_i == operand_b_i;

    // Result path
    always_comb begin
        case (operator_i)
            ex_pkg::OP_SUB:  result_o = operand_a_i - operand_b_i;
            ex_pkg::OP_AND:  result_o = operand_a_i & operand_b_i;
            ex_pkg::OP_OR:   result_o = operand_a_i | operand_b_i;
            ex_pkg::OP_XOR:  result_o = operand_a_i ^ operand_b_i;
            ex_pkg::OP_SLL:  result_o = operand_a_i << shamt;
            ex_pkg::OP_SRL:  result_o = operand_a_i >> shamt;
            ex_pkg::OP_SRA:  result_o = $unsigned($signed(operand_a_i) >>> shamt);
            ex_pkg::OP_SLT:  result_o = {{(`EX_XLEN-1){1'b0}}, less_signed};
            ex_pkg::OP_SLTU: result_o = {{(`EX_XLEN-1){1'b0}}, less_unsigned};
            // ADD and all branch operators
            default:         result_o = operand_a_i + operand_b_i;
        endcase
    end

    // ---------------------------------------------------------
    // Branch comparison
    // ---------------------------------------------------------
    always_comb begin
        case (operator_i)
            ex_pkg::OP_BEQ:  branch_res_o = equal;
            ex_pkg::OP_BNE:  branch_res_o = ~equal;
            ex_pkg::OP_BLT:  branch_res_o = less_signed;
            ex_pkg::OP_BGE:  branch_res_o = ~less_signed;
            ex_pkg::OP_BLTU: branch_res_o = less_unsigned;
            ex_pkg::OP_BGEU: branch_res_o = ~less_unsigned;
            // Jumps are always taken
            ex_pkg::OP_JALR: branch_res_o = 1'b1;
            default:         branch_res_o = 1'b0;
        endcase
    end

endmodule

// ==== source/ex_branch_unit.sv ====
`timescale 1ns/1ps
`include "ex_defines.svh"

module ex_branch_unit (
    input  ex_pkg::fu_op_e        operator_i,
    input  logic [`EX_XLEN-1:0]   operand_a_i,
    input  logic [`EX_XLEN-1:0]   pc_i,
    input  logic [`EX_XLEN-1:0]   imm_i,
    input  logic                  is_compressed_i,
    input  logic                  branch_valid_i,
    input  logic                  branch_res_i,
    input  logic                  predict_taken_i,
    input  logic [`EX_XLEN-1:0]   predict_target_i,
    output logic [`EX_XLEN-1:0]   link_o,
    output logic [`EX_XLEN-1:0]   resolved_target_o,
    output logic                  resolve_branch_o,
    output logic                  resolved_taken_o,
    output logic                  mispredict_o
);

    logic [`EX_XLEN-1:0] target;
    logic [`EX_XLEN-1:0] jump_base;
    logic [`EX_XLEN-1:0] next_pc;
    logic                taken;

    // JALR jumps relative to rs1, everything else to the PC
    assign jump_base = (operator_i == ex_pkg::OP_JALR) ? operand_a_i : pc_i;

    // Bit 0 is only set by a JALR target, clearing it always is harmless
    assign target = (jump_base + imm_i) & ~`EX_XLEN'(1);

    assign next_pc = is_compressed_i ? pc_i + `EX_XLEN'(`EX_CINSTR_BYTES)
                                     : pc_i + `EX_XLEN'(`EX_INSTR_BYTES);

    assign taken = branch_res_i;

    // ---------------------------------------------------------
    // Resolution towards the frontend
    // ---------------------------------------------------------
    always_comb begin
        link_o            = '0;
        resolved_target_o = '0;
        resolve_branch_o  = 1'b0;
        resolved_taken_o  = 1'b0;
        mispredict_o      = 1'b0;
        if (branch_valid_i) begin
            link_o            = next_pc;
            resolve_branch_o  = 1'b1;
            resolved_taken_o  = taken;
            // Not taken continues at the next instruction
            resolved_target_o = taken ? target : next_pc;
            // Wrong direction, or taken to the wrong place
            mispredict_o      = (taken != predict_taken_i)
                              | (taken & (target != predict_target_i));
        end
    end

endmodule

// ==== source/ex_csr_buffer.sv ====
`timescale 1ns/1ps
`include "ex_defines.svh"

module ex_csr_buffer (
    input  logic                           clk_i,
    input  logic                           rst_ni,
    input  logic                           flush_i,
    input  logic                           csr_valid_i,
    input  logic                           csr_commit_i,
    input  logic [`EX_XLEN-1:0]            operand_a_i,
    input  logic [`EX_XLEN-1:0]            operand_b_i,
    output logic [`EX_XLEN-1:0]            csr_result_o,
    output logic                           csr_ready_o,
    output logic [`EX_CSR_ADDR_BITS-1:0]   csr_addr_o
);

    logic                          valid_q;
    logic [`EX_CSR_ADDR_BITS-1:0]  addr_q;

    // Entry state, a new request beats a commit and flush beats both
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            valid_q <= 1'b0;
        end else if (flush_i) begin
            valid_q <= 1'b0;
        end else if (csr_valid_i) begin
            valid_q <= 1'b1;
        end else if (csr_commit_i) begin
            valid_q <= 1'b0;
        end
    end

    always_ff @(posedge clk_i) begin
        if (csr_valid_i) begin
            addr_q <= operand_b_i[`EX_CSR_ADDR_BITS-1:0];
        end
    end

    // Full buffer blocks the issue port
    assign csr_ready_o  = ~valid_q;
    assign csr_addr_o   = addr_q;
    // Write data goes back to the scoreboard unchanged
    assign csr_result_o = operand_a_i;

endmodule

// ==== source/ex_multiplier.sv ====
`timescale 1ns/1ps
`include "ex_defines.svh"

module ex_multiplier (
    input  logic                           clk_i,
    input  logic                           rst_ni,
    input  logic                           flush_i,
    input  logic                           mult_valid_i,
    input  ex_pkg::fu_op_e                 operator_i,
    input  logic [`EX_XLEN-1:0]            operand_a_i,
    input  logic [`EX_XLEN-1:0]            operand_b_i,
    input  logic [`EX_TRANS_ID_BITS-1:0]   trans_id_i,
    output logic [`EX_XLEN-1:0]            result_o,
    output logic                           mult_valid_o,
    output logic [`EX_TRANS_ID_BITS-1:0]   mult_trans_id_o
);

    logic [2*`EX_XLEN-1:0]          product;
    logic [`EX_XLEN-1:0]            result_d;
    logic [`EX_XLEN-1:0]            result_q;
    logic [`EX_TRANS_ID_BITS-1:0]   trans_id_q;
    logic                           valid_q;

    // Full unsigned product, the operator picks the half
    assign product  = operand_a_i * operand_b_i;
    assign result_d = (operator_i == ex_pkg::OP_MULHU) ? product[2*`EX_XLEN-1:`EX_XLEN]
                                                       : product[`EX_XLEN-1:0];

    // Flush kills the multiply in flight
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= mult_valid_i & ~flush_i;
        end
    end

    always_ff @(posedge clk_i) begin
        result_q   <= result_d;
        trans_id_q <= trans_id_i;
    end

    assign result_o        = result_q;
    assign mult_valid_o    = valid_q;
    assign mult_trans_id_o = trans_id_q;

endmodule

// ==== source/ex_control.sv ====
`timescale 1ns/1ps
`include "ex_defines.svh"

module ex_control (
    input  logic                           alu_valid_i,
    input  logic                           branch_valid_i,
    input  logic                           csr_valid_i,
    input  logic                           mult_valid_i,
    input  logic                           mult_done_i,
    input  logic                           csr_ready_i,
    input  logic [`EX_XLEN-1:0]            operand_a_i,
    input  logic [`EX_XLEN-1:0]            operand_b_i,
    input  logic [`EX_XLEN-1:0]            alu_result_i,
    input  logic [`EX_XLEN-1:0]            csr_result_i,
    input  logic [`EX_XLEN-1:0]            mult_result_i,
    input  logic [`EX_XLEN-1:0]            link_i,
    input  logic [`EX_TRANS_ID_BITS-1:0]   trans_id_i,
    input  logic [`EX_TRANS_ID_BITS-1:0]   mult_trans_id_i,
    output logic [`EX_XLEN-1:0]            alu_operand_a_o,
    output logic [`EX_XLEN-1:0]            alu_operand_b_o,
    output logic [`EX_XLEN-1:0]            mult_operand_a_o,
    output logic [`EX_XLEN-1:0]            mult_operand_b_o,
    output logic [`EX_XLEN-1:0]            flu_result_o,
    output logic [`EX_TRANS_ID_BITS-1:0]   flu_trans_id_o,
    output logic                           flu_valid_o,
    output logic                           flu_ready_o
);

    logic alu_active;

    // ---------------------------------------------------------
    // Operand silencing
    // ---------------------------------------------------------
    // Branches need the ALU for the comparison
    assign alu_active = alu_valid_i | branch_valid_i;

    assign alu_operand_a_o  = alu_active   ? operand_a_i : '0;
    assign alu_operand_b_o  = alu_active   ? operand_b_i : '0;
    assign mult_operand_a_o = mult_valid_i ? operand_a_i : '0;
    assign mult_operand_b_o = mult_valid_i ? operand_b_i : '0;

    // ---------------------------------------------------------
    // Write-back selection
    // ---------------------------------------------------------
    always_comb begin
        // Branch link unless another unit writes
        flu_result_o   = link_i;
        flu_trans_id_o = trans_id_i;
        if (alu_valid_i) begin
            flu_result_o = alu_result_i;
        end else if (csr_valid_i) begin
            flu_result_o = csr_result_i;
        end else if (mult_done_i) begin
            flu_result_o   = mult_result_i;
            flu_trans_id_o = mult_trans_id_i;
        end
    end

    assign flu_valid_o = alu_valid_i | branch_valid_i | csr_valid_i | mult_done_i;

    // Multiplier never stalls, only the CSR buffer blocks
    assign flu_ready_o = csr_ready_i;

endmodule

// ==== source/ex_stage.sv ====
`timescale 1ns/1ps
`include "ex_defines.svh"

module ex_stage (
    input  logic                           clk_i,
    input  logic                           rst_ni,
    input  logic                           flush_i,
    // Issue port
    input  ex_pkg::fu_op_e                 operator_i,
    input  logic [`EX_XLEN-1:0]            operand_a_i,
    input  logic [`EX_XLEN-1:0]            operand_b_i,
    input  logic [`EX_XLEN-1:0]            imm_i,
    input  logic [`EX_TRANS_ID_BITS-1:0]   trans_id_i,
    input  logic [`EX_XLEN-1:0]            pc_i,
    input  logic                           is_compressed_i,
    input  logic                           alu_valid_i,
    input  logic                           branch_valid_i,
    input  logic                           csr_valid_i,
    input  logic                           mult_valid_i,
    // Branch prediction and resolution
    input  logic                           predict_taken_i,
    input  logic [`EX_XLEN-1:0]            predict_target_i,
    output logic                           resolve_branch_o,
    output logic                           resolved_taken_o,
    output logic [`EX_XLEN-1:0]            resolved_target_o,
    output logic                           mispredict_o,
    // CSR
    input  logic                           csr_commit_i,
    output logic [`EX_CSR_ADDR_BITS-1:0]   csr_addr_o,
    // Write-back port
    output logic [`EX_XLEN-1:0]            flu_result_o,
    output logic [`EX_TRANS_ID_BITS-1:0]   flu_trans_id_o,
    output logic                           flu_valid_o,
    output logic                           flu_ready_o
);

    logic [`EX_XLEN-1:0]            alu_operand_a;
    logic [`EX_XLEN-1:0]            alu_operand_b;
    logic [`EX_XLEN-1:0]            mult_operand_a;
    logic [`EX_XLEN-1:0]            mult_operand_b;
    logic [`EX_XLEN-1:0]            alu_result;
    logic [`EX_XLEN-1:0]            csr_result;
    logic [`EX_XLEN-1:0]            mult_result;
    logic [`EX_XLEN-1:0]            link;
    logic [`EX_TRANS_ID_BITS-1:0]   mult_trans_id;
    logic                           alu_branch_res;
    logic                           csr_ready;
    logic                           mult_valid;

    ex_control control_i (
        .alu_valid_i      (alu_valid_i),
        .branch_valid_i   (branch_valid_i),
        .csr_valid_i      (csr_valid_i),
        .mult_valid_i     (mult_valid_i),
        .mult_done_i      (mult_valid),
        .csr_ready_i      (csr_ready),
        .operand_a_i      (operand_a_i),
        .operand_b_i      (operand_b_i),
        .alu_result_i     (alu_result),
        .csr_result_i     (csr_result),
        .mult_result_i    (mult_result),
        .link_i           (link),
        .trans_id_i       (trans_id_i),
        .mult_trans_id_i  (mult_trans_id),
        .alu_operand_a_o  (alu_operand_a),
        .alu_operand_b_o  (alu_operand_b),
        .mult_operand_a_o (mult_operand_a),
        .mult_operand_b_o (mult_operand_b),
        .flu_result_o     (flu_result_o),
        .flu_trans_id_o   (flu_trans_id_o),
        .flu_valid_o      (flu_valid_o),
        .flu_ready_o      (flu_ready_o)
    );

    // Single cycle units
    ex_alu alu_i (
        .operator_i   (operator_i),
        .operand_a_i  (alu_operand_a),
        .operand_b_i  (alu_operand_b),
        .result_o     (alu_result),
        .branch_res_o (alu_branch_res)
    );

    ex_branch_unit branch_unit_i (
        .operator_i        (operator_i),
        .operand_a_i       (operand_a_i),
        .pc_i              (pc_i),
        .imm_i             (imm_i),
        .is_compressed_i   (is_compressed_i),
        .branch_valid_i    (branch_valid_i),
        .branch_res_i      (alu_branch_res),
        .predict_taken_i   (predict_taken_i),
        .predict_target_i  (predict_target_i),
        .link_o            (link),
        .resolved_target_o (resolved_target_o),
        .resolve_branch_o  (resolve_branch_o),
        .resolved_taken_o  (resolved_taken_o),
        .mispredict_o      (mispredict_o)
    );

    // Sequential units
    ex_csr_buffer csr_buffer_i (
        .clk_i        (clk_i),
        .rst_ni       (rst_ni),
        .flush_i      (flush_i),
        .csr_valid_i  (csr_valid_i),
        .csr_commit_i (csr_commit_i),
        .operand_a_i  (operand_a_i),
        .operand_b_i  (operand_b_i),
        .csr_result_o (csr_result),
        .csr_ready_o  (csr_ready),
        .csr_addr_o   (csr_addr_o)
    );

    ex_multiplier multiplier_i (
        .clk_i           (clk_i),
        .rst_ni          (rst_ni),
        .flush_i         (flush_i),
        .mult_valid_i    (mult_valid_i),
        .operator_i      (operator_i),
        .operand_a_i     (mult_operand_a),
        .operand_b_i     (mult_operand_b),
        .trans_id_i      (trans_id_i),
        .result_o        (mult_result),
        .mult_valid_o    (mult_valid),
        .mult_trans_id_o (mult_trans_id)
    );

endmodule

// ==== testbench/ex_stage_properties.sv ====
`timescale 1ns/1ps

module ex_stage_properties (
    input logic clk_i,
    input logic rst_ni,
    input logic alu_valid_i,
    input logic branch_valid_i,
    input logic csr_valid_i,
    input logic mult_valid_i,
    input logic flu_valid_o,
    input logic flu_ready_o
);

    logic [3:0] strobes;

    assign strobes = {alu_valid_i, branch_valid_i, csr_valid_i, mult_valid_i};

    // Issue rules
    strobe_onehot: assert property (@(posedge clk_i) disable iff (!rst_ni) $onehot0(strobes))
        else $error("More than one issue strobe high in the same cycle");

    issue_when_ready: assert property (@(posedge clk_i) disable iff (!rst_ni)
        |strobes |-> flu_ready_o)
        else $error("Issue strobe high while the port is not ready");

    // Nothing written back right after reset
    idle_after_reset: assert property (@(posedge clk_i) $rose(rst_ni) |-> !flu_valid_o)
        else $error("Write-back valid high in the first cycle after reset");

endmodule

bind ex_stage ex_stage_properties properties_i (.*);

// ==== testbench/ex_stage_tb.sv ====
`timescale 1ns/1ps
`include "ex_defines.svh"

module ex_stage_tb;

    localparam int NUM_CYCLES = 2000;

    logic                           clk_i = 1'b0;
    logic                           rst_ni;
    logic                           flush_i;
    ex_pkg::fu_op_e                 operator_i;
    logic [`EX_XLEN-1:0]            operand_a_i;
    logic [`EX_XLEN-1:0]            operand_b_i;
    logic [`EX_XLEN-1:0]            imm_i;
    logic [`EX_TRANS_ID_BITS-1:0]   trans_id_i;
    logic [`EX_XLEN-1:0]            pc_i;
    logic                           is_compressed_i;
    logic                           alu_valid_i;
    logic                           branch_valid_i;
    logic                           csr_valid_i;
    logic                           mult_valid_i;
    logic                           predict_taken_i;
    logic [`EX_XLEN-1:0]            predict_target_i;
    logic                           resolve_branch_o;
    logic                           resolved_taken_o;
    logic [`EX_XLEN-1:0]            resolved_target_o;
    logic                           mispredict_o;
    logic                           csr_commit_i;
    logic [`EX_CSR_ADDR_BITS-1:0]   csr_addr_o;
    logic [`EX_XLEN-1:0]            flu_result_o;
    logic [`EX_TRANS_ID_BITS-1:0]   flu_trans_id_o;
    logic                           flu_valid_o;
    logic                           flu_ready_o;

    // Reference model state
    logic                           csr_full;
    logic [`EX_CSR_ADDR_BITS-1:0]   csr_addr;
    logic                           mult_busy;
    logic [`EX_XLEN-1:0]            mult_res;
    logic [`EX_TRANS_ID_BITS-1:0]   mult_id;
    int unsigned                    commit_wait;

    ex_stage ex_stage_i (.*);

    always #5 clk_i = ~clk_i;

    // ------------------------------------------------------------
    // Checks
    // ------------------------------------------------------------
    task automatic stop_run(input string what);
        $display("%s", what);
        $display("STATUS: FAIL");
        $fatal(1, "Simulation stopped");
    endtask

    task automatic check_result(input string name, input logic [`EX_XLEN-1:0] exp,
                                input logic [`EX_XLEN-1:0] act);
        if (act !== exp) begin
            stop_run($sformatf("Mismatch %s: expected %h, actual %h", name, exp, act));
        end
    endtask

    task automatic check_trans_id(input string name, input logic [`EX_TRANS_ID_BITS-1:0] exp,
                                  input logic [`EX_TRANS_ID_BITS-1:0] act);
        if (act !== exp) begin
            stop_run($sformatf("Mismatch %s: expected %h, actual %h", name, exp, act));
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            stop_run($sformatf("Mismatch %s: expected %b, actual %b", name, exp, act));
        end
    endtask

    task automatic check_csr_addr(input string name, input logic [`EX_CSR_ADDR_BITS-1:0] exp,
                                  input logic [`EX_CSR_ADDR_BITS-1:0] act);
        if (act !== exp) begin
            stop_run($sformatf("Mismatch %s: expected %h, actual %h", name, exp, act));
        end
    endtask

    // ------------------------------------------------------------
    // Reference model
    // ------------------------------------------------------------
    function automatic logic [`EX_XLEN-1:0] alu_ref(input ex_pkg::fu_op_e op,
                                                    input logic [`EX_XLEN-1:0] a,
                                                    input logic [`EX_XLEN-1:0] b);
        case (op)
            ex_pkg::OP_SUB:  return a - b;
            ex_pkg::OP_AND:  return a & b;
            ex_pkg::OP_OR:   return a | b;
            ex_pkg::OP_XOR:  return a ^ b;
            ex_pkg::OP_SLL:  return a << b[4:0];
            ex_pkg::OP_SRL:  return a >> b[4:0];
            ex_pkg::OP_SRA:  return $signed(a) >>> b[4:0];
            ex_pkg::OP_SLT:  return `EX_XLEN'($signed(a) < $signed(b));
            ex_pkg::OP_SLTU: return `EX_XLEN'(a < b);
            default:         return a + b;
        endcase
    endfunction

    function automatic logic taken_ref(input ex_pkg::fu_op_e op, input logic [`EX_XLEN-1:0] a,
                                       input logic [`EX_XLEN-1:0] b);
        case (op)
            ex_pkg::OP_BEQ:  return a == b;
            ex_pkg::OP_BNE:  return a != b;
            ex_pkg::OP_BLT:  return $signed(a) < $signed(b);
            ex_pkg::OP_BGE:  return $signed(a) >= $signed(b);
            ex_pkg::OP_BLTU: return a < b;
            ex_pkg::OP_BGEU: return a >= b;
            default:         return 1'b1;
        endcase
    endfunction

    function automatic logic [`EX_XLEN-1:0] target_ref(input ex_pkg::fu_op_e op,
                                                       input logic [`EX_XLEN-1:0] a,
                                                       input logic [`EX_XLEN-1:0] pc,
                                                       input logic [`EX_XLEN-1:0] imm);
        if (op == ex_pkg::OP_JALR) begin
            return (a + imm) & ~`EX_XLEN'(1);
        end
        return pc + imm;
    endfunction

    // State update on the inputs seen at the rising edge
    task automatic update_model();
        logic [2*`EX_XLEN-1:0] product;
        product   = {{`EX_XLEN{1'b0}}, operand_a_i} * {{`EX_XLEN{1'b0}}, operand_b_i};
        mult_busy = mult_valid_i && !flush_i;
        mult_res  = (operator_i == ex_pkg::OP_MULHU) ? product[2*`EX_XLEN-1:`EX_XLEN]
                                                     : product[`EX_XLEN-1:0];
        mult_id   = trans_id_i;
        if (flush_i) begin
            csr_full = 1'b0;
        end else if (csr_valid_i) begin
            csr_full    = 1'b1;
            csr_addr    = operand_b_i[`EX_CSR_ADDR_BITS-1:0];
            commit_wait = $urandom_range(0, 3);
        end else if (csr_commit_i) begin
            csr_full = 1'b0;
        end
    endtask

    // ------------------------------------------------------------
    // Stimulus
    // ------------------------------------------------------------
    task automatic drive_next(input logic allow_issue);
        int unsigned         kind;
        logic [`EX_XLEN-1:0] a;
        logic [`EX_XLEN-1:0] pc;
        logic [`EX_XLEN-1:0] imm;
        ex_pkg::fu_op_e      op;
        kind = allow_issue ? $urandom_range(0, 5) : 5;
        // Full buffer blocks everything, a pending product owns the write port
        if (csr_full) begin
            kind = 5;
        end else if (mult_busy && kind < 4) begin
            kind = ($urandom_range(0, 1) == 0) ? 4 : 5;
        end
        a   = $urandom;
        pc  = $urandom & ~`EX_XLEN'(1);
        imm = $urandom & ~`EX_XLEN'(1);
        case (kind)
            0, 1:    op = ex_pkg::fu_op_e'($urandom_range(0, 9));
            2:       op = ex_pkg::fu_op_e'($urandom_range(10, 16));
            3:       op = ex_pkg::OP_CSR;
            4:       op = $urandom_range(0, 1) ? ex_pkg::OP_MULHU : ex_pkg::OP_MUL;
            default: op = ex_pkg::OP_ADD;
        endcase
        // Odd JALR sums check the bit 0 clearing
        if (op == ex_pkg::OP_JALR) begin
            imm = $urandom;
        end
        operator_i  <= op;
        operand_a_i <= a;
        case ($urandom_range(0, 3))
            0:       operand_b_i <= a;
            1:       operand_b_i <= $urandom_range(0, 40);
            default: operand_b_i <= $urandom;
        endcase
        imm_i            <= imm;
        pc_i             <= pc;
        trans_id_i       <= `EX_TRANS_ID_BITS'($urandom);
        is_compressed_i  <= $urandom_range(0, 1);
        alu_valid_i      <= kind < 2;
        branch_valid_i   <= kind == 2;
        csr_valid_i      <= kind == 3;
        mult_valid_i     <= kind == 4;
        predict_taken_i  <= $urandom_range(0, 1);
        predict_target_i <= $urandom_range(0, 1) ? target_ref(op, a, pc, imm)
                                                 : ($urandom & ~`EX_XLEN'(1));
        flush_i          <= (kind != 3) && ($urandom_range(0, 7) == 0);
        csr_commit_i     <= csr_full && (commit_wait == 0);
        if (csr_full && commit_wait != 0) begin
            commit_wait--;
        end
    endtask

    task automatic check_outputs();
        logic [`EX_XLEN-1:0]          link;
        logic [`EX_XLEN-1:0]          target;
        logic [`EX_XLEN-1:0]          exp_result;
        logic [`EX_TRANS_ID_BITS-1:0] exp_id;
        logic                         taken;
        link       = pc_i + (is_compressed_i ? 2 : 4);
        target     = target_ref(operator_i, operand_a_i, pc_i, imm_i);
        taken      = taken_ref(operator_i, operand_a_i, operand_b_i);
        exp_id     = trans_id_i;
        exp_result = branch_valid_i ? link : '0;
        if (alu_valid_i) begin
            exp_result = alu_ref(operator_i, operand_a_i, operand_b_i);
        end else if (csr_valid_i) begin
            exp_result = operand_a_i;
        end else if (mult_busy) begin
            exp_result = mult_res;
            exp_id     = mult_id;
        end
        check_bit("flu_valid_o", alu_valid_i | branch_valid_i | csr_valid_i | mult_busy,
                  flu_valid_o);
        check_bit("flu_ready_o", !csr_full, flu_ready_o);
        check_result("flu_result_o", exp_result, flu_result_o);
        check_trans_id("flu_trans_id_o", exp_id, flu_trans_id_o);
        check_bit("resolve_branch_o", branch_valid_i, resolve_branch_o);
        check_bit("resolved_taken_o", branch_valid_i && taken, resolved_taken_o);
        check_result("resolved_target_o", branch_valid_i ? (taken ? target : link) : '0,
                     resolved_target_o);
        check_bit("mispredict_o", branch_valid_i && ((taken != predict_taken_i)
                  || (taken && target != predict_target_i)), mispredict_o);
        if (csr_full) begin
            check_csr_addr("csr_addr_o", csr_addr, csr_addr_o);
        end
    endtask

    // Drive on the rising edge, sample on the falling edge
    task automatic run_cycle(input logic allow_issue);
        @(posedge clk_i);
        update_model();
        drive_next(allow_issue);
        @(negedge clk_i);
        check_outputs();
    endtask

    initial begin
        int unsigned stall;
        void'($urandom(95));
        rst_ni           = 1'b0;
        flush_i          = 1'b0;
        operator_i       = ex_pkg::OP_ADD;
        operand_a_i      = '0;
        operand_b_i      = '0;
        imm_i            = '0;
        trans_id_i       = '0;
        pc_i             = '0;
        is_compressed_i  = 1'b0;
        alu_valid_i      = 1'b0;
        branch_valid_i   = 1'b0;
        csr_valid_i      = 1'b0;
        mult_valid_i     = 1'b0;
        predict_taken_i  = 1'b0;
        predict_target_i = '0;
        csr_commit_i     = 1'b0;
        csr_full         = 1'b0;
        mult_busy        = 1'b0;
        commit_wait      = 0;
        stall            = 0;
        repeat (5) @(posedge clk_i);
        rst_ni <= 1'b1;
        @(negedge clk_i);
        check_bit("reset flu_valid_o", 1'b0, flu_valid_o);
        check_bit("reset resolve_branch_o", 1'b0, resolve_branch_o);
        check_bit("reset flu_ready_o", 1'b1, flu_ready_o);

        for (int i = 0; i < NUM_CYCLES; i++) begin
            run_cycle(1'b1);
        end

        // Let the last CSR entry and multiply retire
        while (!flu_ready_o || flu_valid_o || mult_valid_i) begin
            run_cycle(1'b0);
            stall++;
            if (stall > 16) begin
                stop_run("Pending CSR entry or multiply did not drain within 16 cycles");
            end
        end
        $display("STATUS: PASS");
        $finish;
    end

endmodule

// ==== project.f ====
+incdir+include
source/ex_pkg.sv
source/ex_alu.sv
source/ex_branch_unit.sv
source/ex_csr_buffer.sv
source/ex_multiplier.sv
source/ex_control.sv
source/ex_stage.sv
testbench/ex_stage_properties.sv
testbench/ex_stage_tb.sv
